// File: dmem_adapter.f
+incdir+hdl
hdl/dmem_pkg.sv
hdl/addr_fifo.sv
hdl/dcache_wr_path.sv
hdl/dcache_rd_path.sv
hdl/dmem_adapter.sv
testbench/tb_clock_gen.sv
testbench/wide_mem_model.sv
testbench/dmem_adapter_tb.sv

// File: hdl/addr_fifo.sv
/* Request address FIFO
   Holds accepted addresses until their data beat has been aligned */

`timescale 1ns/1ps
`default_nettype none

module addr_fifo #(
    parameter int DEPTH = 4,
    parameter int WIDTH = 16
) (
    input  wire              aclk,
    input  wire              arst_n,
    input  wire  [WIDTH-1:0] data_in,
    input  wire              push,
    output logic             full,
    output logic [WIDTH-1:0] data_out,
    input  wire              pull,
    output logic             empty
);

    // Pointer and occupancy widths
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Address storage
    logic [WIDTH-1:0] mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    //////////////////////////////
    // Storage write
    //////////////////////////////

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    //////////////////////////////
    // Pointers and occupancy
    //////////////////////////////

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Wrap explicitly so DEPTH need not be a power of two
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pull) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pull})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head entry straight from the register array
    assign data_out = mem[rd_ptr];
    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Callers must gate their handshakes with full and empty
    push_not_full: assert property (@(posedge aclk) disable iff (!arst_n)
        !(push && full));
    pull_not_empty: assert property (@(posedge aclk) disable iff (!arst_n)
        !(pull && empty));

endmodule

`default_nettype wire

// File: hdl/dcache_rd_path.sv
/* Data memory read path
   Forwards read addresses and picks the narrow lane out of each wide read beat */

`timescale 1ns/1ps
`default_nettype none

`include "dmem_consts.svh"

module dcache_rd_path import dmem_pkg::*; (
    input  wire        aclk,
    input  wire        arst_n,
    // Narrow side from the load/store unit
    input  req_a_t     n_ar,
    input  wire        n_ar_valid,
    output logic       n_ar_ready,
    output narrow_r_t  n_r,
    output logic       n_r_valid,
    input  wire        n_r_ready,
    // Wide side toward central memory
    output req_a_t     m_ar,
    output logic       m_ar_valid,
    input  wire        m_ar_ready,
    input  wide_r_t    m_r,
    input  wire        m_r_valid,
    output logic       m_r_ready
);

    // Status of the address FIFO
    logic               rd_full;
    logic               rd_empty;
    logic [`ADDR_W-1:0] rd_head;
    // Lane of the oldest pending read
    logic [`LANE_SEL_W-1:0] rd_lane;

    //////////////////////////////
    // Read address channel
    //////////////////////////////

    // Responses return in order, so the head matches the next beat
    addr_fifo #(
        .DEPTH (`OSTD_NUM),
        .WIDTH (`ADDR_W)
    ) rd_fifo (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .data_in  (n_ar.addr),
        .push     (n_ar_valid & n_ar_ready),
        .full     (rd_full),
        .data_out (rd_head),
        .pull     (m_r_valid & m_r_ready & m_r.last),
        .empty    (rd_empty)
    );

    // Limit outstanding reads to the FIFO depth
    assign m_ar_valid = n_ar_valid & ~rd_full;
    assign n_ar_ready = m_ar_ready & ~rd_full;

    always_comb begin
        m_ar.addr = n_ar.addr;
        m_ar.id   = n_ar.id | `ID_MASK;
    end

    //////////////////////////////
    // Read data channel
    //////////////////////////////

    assign rd_lane = rd_head[`LANE_LSB +: `LANE_SEL_W];

    // Lane view of the union does the selection
    always_comb begin
        n_r.data = m_r.data.lane[rd_lane];
        n_r.id   = m_r.id;
        n_r.resp = m_r.resp;
    end

    assign n_r_valid = m_r_valid;
    assign m_r_ready = n_r_ready;

    // Memory answers only requests that were forwarded
    r_has_addr: assert property (@(posedge aclk) disable iff (!arst_n)
        m_r_valid |-> !rd_empty);
    // Single-beat memory, every read beat closes its burst
    r_single_beat: assert property (@(posedge aclk) disable iff (!arst_n)
        m_r_valid |-> m_r.last);

endmodule

`default_nettype wire

// File: hdl/dcache_wr_path.sv
/* Data memory write path
   Forwards write addresses, places narrow write data in its wide lane, returns responses */

`timescale 1ns/1ps
`default_nettype none

`include "dmem_consts.svh"

module dcache_wr_path import dmem_pkg::*; (
    input  wire        aclk,
    input  wire        arst_n,
    // Narrow side from the load/store unit
    input  req_a_t     n_aw,
    input  wire        n_aw_valid,
    output logic       n_aw_ready,
    input  narrow_w_t  n_w,
    input  wire        n_w_valid,
    output logic       n_w_ready,
    output resp_b_t    n_b,
    output logic       n_b_valid,
    input  wire        n_b_ready,
    // Wide side toward central memory
    output req_a_t     m_aw,
    output logic       m_aw_valid,
    input  wire        m_aw_ready,
    output wide_w_t    m_w,
    output logic       m_w_valid,
    input  wire        m_w_ready,
    input  resp_b_t    m_b,
    input  wire        m_b_valid,
    output logic       m_b_ready
);

    // Status of the address FIFO
    logic               wr_full;
    logic               wr_empty;
    logic [`ADDR_W-1:0] wr_head;
    // Lane index taken from the head address
    logic [`LANE_SEL_W-1:0] wr_lane;

    //////////////////////////////
    // Write address channel
    //////////////////////////////

    // Address kept for lane placement of the matching data beat
    // Popped once that beat is accepted by memory
    addr_fifo #(
        .DEPTH (`OSTD_NUM),
        .WIDTH (`ADDR_W)
    ) wr_fifo (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .data_in  (n_aw.addr),
        .push     (n_aw_valid & n_aw_ready),
        .full     (wr_full),
        .data_out (wr_head),
        .pull     (m_w_valid & m_w_ready),
        .empty    (wr_empty)
    );

    // Full FIFO stalls new addresses in both directions
    assign m_aw_valid = n_aw_valid & ~wr_full;
    assign n_aw_ready = m_aw_ready & ~wr_full;

    // Address passes unchanged with the ID tagged as data-side traffic
    always_comb begin
        m_aw.addr = n_aw.addr;
        m_aw.id   = n_aw.id | `ID_MASK;
    end

    //////////////////////////////
    // Write data channel
    //////////////////////////////

    assign wr_lane = wr_head[`LANE_LSB +: `LANE_SEL_W];

    // Data is held back until its address is at the FIFO head
    assign m_w_valid = n_w_valid & ~wr_empty;
    assign n_w_ready = m_w_ready & ~wr_empty;

    // Replicate data into all lanes
    // Only the addressed lane gets the byte strobes
    always_comb begin
        for (int i = 0; i < `LANES; i++) begin
            m_w.data.lane[i] = n_w.data;
            if (i == wr_lane) begin
                m_w.strb[i*(`XLEN/8) +: `XLEN/8] = n_w.strb;
            end else begin
                m_w.strb[i*(`XLEN/8) +: `XLEN/8] = '0;
            end
        end
    end

    //////////////////////////////
    // Write response channel
    //////////////////////////////

    // Tagged ID comes back from memory untouched
    assign n_b       = m_b;
    assign n_b_valid = m_b_valid;
    assign m_b_ready = n_b_ready;

endmodule

`default_nettype wire

// File: hdl/dmem_adapter.sv
/* Data memory adapter top level
   Joins the narrow load/store port to the wide memory through write and read paths */

`timescale 1ns/1ps
`default_nettype none

module dmem_adapter import dmem_pkg::*; (
    input  wire        aclk,
    input  wire        arst_n,
    // Narrow port, load/store unit side
    input  req_a_t     n_aw,
    input  wire        n_aw_valid,
    output logic       n_aw_ready,
    input  narrow_w_t  n_w,
    input  wire        n_w_valid,
    output logic       n_w_ready,
    output resp_b_t    n_b,
    output logic       n_b_valid,
    input  wire        n_b_ready,
    input  req_a_t     n_ar,
    input  wire        n_ar_valid,
    output logic       n_ar_ready,
    output narrow_r_t  n_r,
    output logic       n_r_valid,
    input  wire        n_r_ready,
    // Wide port, central memory side
    output req_a_t     m_aw,
    output logic       m_aw_valid,
    input  wire        m_aw_ready,
    output wide_w_t    m_w,
    output logic       m_w_valid,
    input  wire        m_w_ready,
    input  resp_b_t    m_b,
    input  wire        m_b_valid,
    output logic       m_b_ready,
    output req_a_t     m_ar,
    output logic       m_ar_valid,
    input  wire        m_ar_ready,
    input  wide_r_t    m_r,
    input  wire        m_r_valid,
    output logic       m_r_ready
);

    //////////////////////////////
    // Write direction
    //////////////////////////////

    dcache_wr_path wr_path (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .n_aw       (n_aw),
        .n_aw_valid (n_aw_valid),
        .n_aw_ready (n_aw_ready),
        .n_w        (n_w),
        .n_w_valid  (n_w_valid),
        .n_w_ready  (n_w_ready),
        .n_b        (n_b),
        .n_b_valid  (n_b_valid),
        .n_b_ready  (n_b_ready),
        .m_aw       (m_aw),
        .m_aw_valid (m_aw_valid),
        .m_aw_ready (m_aw_ready),
        .m_w        (m_w),
        .m_w_valid  (m_w_valid),
        .m_w_ready  (m_w_ready),
        .m_b        (m_b),
        .m_b_valid  (m_b_valid),
        .m_b_ready  (m_b_ready)
    );

    //////////////////////////////
    // Read direction
    //////////////////////////////

    // Independent of writes, no ordering between the two
    dcache_rd_path rd_path (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .n_ar       (n_ar),
        .n_ar_valid (n_ar_valid),
        .n_ar_ready (n_ar_ready),
        .n_r        (n_r),
        .n_r_valid  (n_r_valid),
        .n_r_ready  (n_r_ready),
        .m_ar       (m_ar),
        .m_ar_valid (m_ar_valid),
        .m_ar_ready (m_ar_ready),
        .m_r        (m_r),
        .m_r_valid  (m_r_valid),
        .m_r_ready  (m_r_ready)
    );

endmodule

`default_nettype wire

// File: hdl/dmem_consts.svh
/* Data memory port constants
   Bus widths, FIFO depth and the ID mask of the data-memory adapter */

`ifndef DMEM_CONSTS_SVH
`define DMEM_CONSTS_SVH

//////////////////////////////
// Bus widths
//////////////////////////////

// Narrow load/store data width
`define XLEN 32
// Central memory data width
`define WIDE_W 128
// Byte address width on both sides
`define ADDR_W 16
// Request and response ID width
`define ID_W 8

//////////////////////////////
// Request tagging and depth
//////////////////////////////

// Marks data-side traffic in the memory interconnect
`define ID_MASK 8'h20
// Outstanding requests per direction
`define OSTD_NUM 4

//////////////////////////////
// Lane geometry
//////////////////////////////

// Narrow lanes in one wide word
`define LANES (`WIDE_W / `XLEN)
// Byte offset bits inside a lane
`define LANE_LSB $clog2(`XLEN / 8)
// Address bits that pick the lane
`define LANE_SEL_W $clog2(`LANES)

`endif

// File: hdl/dmem_pkg.sv
/* Data memory port types
   Channel payload structs and the two-way view of a wide data word */

`default_nettype none

`include "dmem_consts.svh"

package dmem_pkg;

    //////////////////////////////
    // Address channels
    //////////////////////////////

    // Shared by aw and ar on both sides
    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        logic [`ID_W-1:0]   id;
    } req_a_t;

    //////////////////////////////
    // Write channels
    //////////////////////////////

    // Narrow write beat from the load/store unit
    typedef struct packed {
        logic [`XLEN-1:0]   data;
        logic [`XLEN/8-1:0] strb;
    } narrow_w_t;

    // Wide word seen as a flat vector or as narrow lanes
    // Lane 0 sits in the least significant bits
    typedef union packed {
        logic [`WIDE_W-1:0]             flat;
        logic [`LANES-1:0][`XLEN-1:0]   lane;
    } wide_word_u;

    // Wide write beat toward memory
    typedef struct packed {
        wide_word_u           data;
        logic [`WIDE_W/8-1:0] strb;
    } wide_w_t;

    // Write response, same on both sides
    typedef struct packed {
        logic [`ID_W-1:0] id;
        logic [1:0]       resp;
    } resp_b_t;

    //////////////////////////////
    // Read channels
    //////////////////////////////

    // Narrow read beat back to the load/store unit
    typedef struct packed {
        logic [`XLEN-1:0] data;
        logic [`ID_W-1:0] id;
        logic [1:0]       resp;
    } narrow_r_t;

    // Wide read beat from memory
    typedef struct packed {
        wide_word_u       data;
        logic [`ID_W-1:0] id;
        logic [1:0]       resp;
        logic             last;
    } wide_r_t;

endpackage

`default_nettype wire

// File: testbench/dmem_adapter_tb.sv
/* Data memory adapter testbench
   Directed lane, ID, outstanding-limit, back-pressure and error-response tests */

`timescale 1ns/1ps
`default_nettype none

`include "dmem_consts.svh"

module dmem_adapter_tb import dmem_pkg::*; ();

    // About 20 transactions of at most ~40 cycles each plus margin
    localparam int CYCLE_LIMIT = 2000;

    logic aclk;
    logic arst_n;
    // Narrow port driven as the load/store unit
    req_a_t    n_aw;
    logic      n_aw_valid, n_aw_ready;
    narrow_w_t n_w;
    logic      n_w_valid, n_w_ready;
    resp_b_t   n_b;
    logic      n_b_valid, n_b_ready;
    req_a_t    n_ar;
    logic      n_ar_valid, n_ar_ready;
    narrow_r_t n_r;
    logic      n_r_valid, n_r_ready;
    // Wide port between DUT and memory model
    req_a_t    m_aw;
    logic      m_aw_valid, m_aw_ready;
    wide_w_t   m_w;
    logic      m_w_valid, m_w_ready;
    resp_b_t   m_b;
    logic      m_b_valid, m_b_ready;
    req_a_t    m_ar;
    logic      m_ar_valid, m_ar_ready;
    wide_r_t   m_r;
    logic      m_r_valid, m_r_ready;
    // Memory model controls and capture
    logic               hold_r;
    logic [`ADDR_W-1:0] err_addr;
    wide_word_u         last_w_data;
    logic [15:0]        last_w_strb;

    int cycles = 0;
    int checks = 0;
    int errors = 0;
    // Lanes written so far with the latest last
    logic [`ADDR_W-1:0] ref_addr [$];
    logic [`XLEN-1:0]   ref_data [$];

    tb_clock_gen #(.PERIOD_NS(100)) clock_gen (.clk(aclk));
    dmem_adapter dmem_adapter_inst (.*);
    wide_mem_model mem_model (.*);

    //////////////////////////////
    // Reference and checks
    //////////////////////////////

    // Initial memory contents of one lane
    function automatic logic [`XLEN-1:0] fill_lane(input logic [`ADDR_W-1:0] addr);
        logic [15:0] a;
        a = {4'h0, addr[11:2], 2'b00};
        return {a, a ^ 16'hA5C3};
    endfunction

    function automatic logic [`XLEN-1:0] lane_value(input logic [`ADDR_W-1:0] addr);
        logic [`XLEN-1:0] v;
        v = fill_lane(addr);
        foreach (ref_addr[i]) begin
            if (ref_addr[i][11:2] == addr[11:2]) begin
                v = ref_data[i];
            end
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Error at cycle %0d: %s", cycles, what);
        end
    endtask

    task automatic check_read(input narrow_r_t r, input logic [`ADDR_W-1:0] addr,
                              input logic [`ID_W-1:0] id, input logic [1:0] exp_resp);
        check_value("n_r.data", r.data, lane_value(addr));
        check_value("n_r.id", r.id, id | `ID_MASK);
        check_value("n_r.resp", r.resp, exp_resp);
    endtask

    //////////////////////////////
    // Transactions
    //////////////////////////////

    // One write whose response is left pending for stall cycles before it is taken
    task automatic write_word(input logic [`ADDR_W-1:0] addr, input logic [`ID_W-1:0] id,
                              input logic [`XLEN-1:0] data, input logic [3:0] strb,
                              input logic [1:0] exp_resp, input int stall);
        resp_b_t          held;
        logic [`XLEN-1:0] merged;
        int               lane;
        lane   = int'(addr[`LANE_LSB +: `LANE_SEL_W]);
        merged = lane_value(addr);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        @(posedge aclk);
        n_aw       <= {addr, id};
        n_aw_valid <= 1'b1;
        n_w        <= {data, strb};
        n_w_valid  <= 1'b1;
        do @(posedge aclk); while (!(n_aw_valid && n_aw_ready));
        // Data waits until its address has reached the FIFO head
        check_value("m_w_valid", m_w_valid, 1'b0);
        n_aw_valid <= 1'b0;
        do @(posedge aclk); while (!(n_w_valid && n_w_ready));
        n_w_valid <= 1'b0;
        if (stall > 0) begin
            do @(posedge aclk); while (!n_b_valid);
            held = n_b;
            repeat (stall) begin
                @(posedge aclk);
                check_true(n_b_valid && n_b == held, "write response changed while stalled");
            end
        end
        n_b_ready <= 1'b1;
        do @(posedge aclk); while (!(n_b_valid && n_b_ready));
        held = n_b;
        n_b_ready <= 1'b0;
        check_value("n_b.id", held.id, id | `ID_MASK);
        check_value("n_b.resp", held.resp, exp_resp);
        // Strobes only in the addressed lane and data present there
        check_value("m_w.strb", last_w_strb, {12'h0, strb} << ((`XLEN / 8) * lane));
        check_value("m_w.data lane", last_w_data.lane[lane], data);
        if (stall > 0) begin
            @(posedge aclk);
            check_true(!n_b_valid, "write response seen twice");
        end
        ref_addr.push_back(addr);
        ref_data.push_back(merged);
    endtask

    task automatic read_word(input logic [`ADDR_W-1:0] addr, input logic [`ID_W-1:0] id,
                             input logic [1:0] exp_resp, input int stall);
        narrow_r_t held;
        @(posedge aclk);
        n_ar       <= {addr, id};
        n_ar_valid <= 1'b1;
        do @(posedge aclk); while (!(n_ar_valid && n_ar_ready));
        n_ar_valid <= 1'b0;
        if (stall > 0) begin
            do @(posedge aclk); while (!n_r_valid);
            held = n_r;
            repeat (stall) begin
                @(posedge aclk);
                check_true(n_r_valid && n_r == held, "read response changed while stalled");
            end
        end
        n_r_ready <= 1'b1;
        do @(posedge aclk); while (!(n_r_valid && n_r_ready));
        held = n_r;
        n_r_ready <= 1'b0;
        check_read(held, addr, id, exp_resp);
        if (stall > 0) begin
            @(posedge aclk);
            check_true(!n_r_valid, "read response seen twice");
        end
    endtask

    // Four reads fill the FIFO and the fifth waits for the first response
    task automatic outstanding_limit();
        int first_r_cycle;
        int fifth_ar_cycle;
        @(posedge aclk);
        hold_r <= 1'b1;
        for (int i = 0; i < 4; i++) begin
            n_ar       <= {16'h0104 + 16'(4 * i), 8'(8'h41 + i)};
            n_ar_valid <= 1'b1;
            do @(posedge aclk); while (!(n_ar_valid && n_ar_ready));
        end
        n_ar <= {16'h0114, 8'h45};
        repeat (6) begin
            @(posedge aclk);
            check_true(!n_ar_ready, "fifth read accepted with four outstanding");
        end
        hold_r    <= 1'b0;
        n_r_ready <= 1'b1;
        fork
            begin
                do @(posedge aclk); while (!(n_ar_valid && n_ar_ready));
                fifth_ar_cycle = cycles;
                n_ar_valid <= 1'b0;
            end
            begin
                for (int i = 0; i < 5; i++) begin
                    do @(posedge aclk); while (!(n_r_valid && n_r_ready));
                    if (i == 0) begin
                        first_r_cycle = cycles;
                    end
                    check_read(n_r, 16'h0104 + 16'(4 * i), 8'(8'h41 + i), 2'b00);
                end
                n_r_ready <= 1'b0;
            end
        join
        check_true(fifth_ar_cycle > first_r_cycle, "fifth read accepted before a slot freed");
    endtask

    //////////////////////////////
    // Run control
    //////////////////////////////

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, a handshake never completed", cycles);
            $display("Checks: %0d, errors: %0d", checks, errors + 1);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        arst_n     = 1'b0;
        n_aw       = '0;
        n_aw_valid = 1'b0;
        n_w        = '0;
        n_w_valid  = 1'b0;
        n_b_ready  = 1'b0;
        n_ar       = '0;
        n_ar_valid = 1'b0;
        n_r_ready  = 1'b0;
        hold_r     = 1'b0;
        err_addr   = 16'hFFFF;
        repeat (10) @(posedge aclk);
        arst_n <= 1'b1;
        // Lane placement with one word per lane and IDs with and without the mask bit
        write_word(16'h0040, 8'h01, 32'hDEAD_BEEF, 4'hF, 2'b00, 0);
        write_word(16'h0044, 8'h22, 32'h1234_5678, 4'h3, 2'b00, 0);
        write_word(16'h0048, 8'h13, 32'hCAFE_F00D, 4'hC, 2'b00, 0);
        write_word(16'h004C, 8'h84, 32'h0BAD_1DEA, 4'h5, 2'b00, 0);
        // Read back through lane selection
        for (int i = 0; i < 4; i++) begin
            read_word(16'h0040 + 16'(4 * i), 8'(8'h50 + i), 2'b00, 0);
        end
        outstanding_limit();
        // Responses held back by the load/store unit
        write_word(16'h0080, 8'h07, 32'h5555_AAAA, 4'hF, 2'b00, 5);
        read_word(16'h0080, 8'h27, 2'b00, 5);
        // SLVERR from memory on one address
        @(posedge aclk);
        err_addr <= 16'h00C4;
        write_word(16'h00C4, 8'h09, 32'h7777_0000, 4'hF, 2'b10, 0);
        read_word(16'h00C4, 8'h0A, 2'b10, 0);
        repeat (2) @(posedge aclk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
/* Testbench clock source
   Free-running clock for the data memory adapter testbench */

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    // Starts low so the first rising edge comes half a period in
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: testbench/wide_mem_model.sv
/* Wide memory model
   Single-beat memory slave with LFSR response delays, an error address and write capture */

`timescale 1ns/1ps
`default_nettype none

`include "dmem_consts.svh"

module wide_mem_model import dmem_pkg::*; (
    input  wire                  aclk,
    input  wire                  arst_n,
    input  req_a_t               m_aw,
    input  wire                  m_aw_valid,
    output logic                 m_aw_ready,
    input  wide_w_t              m_w,
    input  wire                  m_w_valid,
    output logic                 m_w_ready,
    output resp_b_t              m_b,
    output logic                 m_b_valid,
    input  wire                  m_b_ready,
    input  req_a_t               m_ar,
    input  wire                  m_ar_valid,
    output logic                 m_ar_ready,
    output wide_r_t              m_r,
    output logic                 m_r_valid,
    input  wire                  m_r_ready,
    // Test controls
    input  wire                  hold_r,
    input  wire  [`ADDR_W-1:0]   err_addr,
    // Last accepted write beat
    output wide_word_u           last_w_data,
    output logic [`WIDE_W/8-1:0] last_w_strb
);

    localparam logic [16:0] LFSR_SEED = 17'd70064;

    // 256 wide words, indexed by address bits 11:4
    wide_word_u  mem [256];
    // Accepted read requests, oldest at ar_rd
    req_a_t      ar_buf [16];
    logic [3:0]  ar_wr;
    logic [3:0]  ar_rd;
    logic [16:0] wr_lfsr;
    logic [16:0] rd_lfsr;

    //////////////////////////////
    // Random delays
    //////////////////////////////

    // Fibonacci LFSR, taps 17 and 14
    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    // Two bits per delay, 0 to 3 cycles
    task automatic draw_delay(inout logic [16:0] state, output int delay);
        delay = 0;
        repeat (2) begin
            delay = (delay << 1) | int'(state[16]);
            state = lfsr_step(state);
        end
    endtask

    // Each lane starts out as its own byte address and a scrambled copy
    initial begin
        logic [15:0] a;
        for (int i = 0; i < 256; i++) begin
            for (int j = 0; j < `LANES; j++) begin
                a = 16'(i * 16 + j * 4);
                mem[i].lane[j] = {a, a ^ 16'hA5C3};
            end
        end
    end

    //////////////////////////////
    // Write side
    //////////////////////////////

    // One write at a time: address, then data, then response
    initial begin
        req_a_t aw_req;
        int     delay;
        m_aw_ready  = 1'b0;
        m_w_ready   = 1'b0;
        m_b_valid   = 1'b0;
        m_b         = '0;
        last_w_data = '0;
        last_w_strb = '0;
        wr_lfsr     = LFSR_SEED;
        wait (arst_n);
        @(posedge aclk);
        forever begin
            m_aw_ready <= 1'b1;
            do @(posedge aclk); while (!(m_aw_valid && m_aw_ready));
            aw_req = m_aw;
            m_aw_ready <= 1'b0;
            m_w_ready  <= 1'b1;
            do @(posedge aclk); while (!(m_w_valid && m_w_ready));
            m_w_ready   <= 1'b0;
            last_w_data <= m_w.data;
            last_w_strb <= m_w.strb;
            // Byte merge under the strobes
            for (int b = 0; b < `WIDE_W / 8; b++) begin
                if (m_w.strb[b]) begin
                    mem[aw_req.addr[11:4]].flat[b*8 +: 8] = m_w.data.flat[b*8 +: 8];
                end
            end
            draw_delay(wr_lfsr, delay);
            repeat (delay) @(posedge aclk);
            m_b       <= {aw_req.id, (aw_req.addr == err_addr) ? 2'b10 : 2'b00};
            m_b_valid <= 1'b1;
            do @(posedge aclk); while (!(m_b_valid && m_b_ready));
            m_b_valid <= 1'b0;
        end
    end

    //////////////////////////////
    // Read side
    //////////////////////////////

    // Requests are always accepted and queued
    always @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            ar_wr <= '0;
        end else if (m_ar_valid && m_ar_ready) begin
            ar_buf[ar_wr] <= m_ar;
            ar_wr         <= ar_wr + 1'b1;
        end
    end

    // Responses in request order, held off while hold_r is high
    initial begin
        req_a_t ar_req;
        int     delay;
        m_ar_ready = 1'b0;
        m_r_valid  = 1'b0;
        m_r        = '0;
        ar_rd      = '0;
        rd_lfsr    = LFSR_SEED;
        wait (arst_n);
        @(posedge aclk);
        m_ar_ready <= 1'b1;
        forever begin
            @(posedge aclk);
            if (ar_wr != ar_rd && !hold_r) begin
                ar_req = ar_buf[ar_rd];
                ar_rd  = ar_rd + 1'b1;
                draw_delay(rd_lfsr, delay);
                repeat (delay) @(posedge aclk);
                m_r <= {mem[ar_req.addr[11:4]], ar_req.id,
                        (ar_req.addr == err_addr) ? 2'b10 : 2'b00, 1'b1};
                m_r_valid <= 1'b1;
                do @(posedge aclk); while (!(m_r_valid && m_r_ready));
                m_r_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire
